// File: common/lane_ctrl_macros.svh
`ifndef LANE_CTRL_MACROS_SVH
`define LANE_CTRL_MACROS_SVH

////////////////////////////////////////////////////////////////////////
// configuration space
////////////////////////////////////////////////////////////////////////

`define LC_CFG_ADDR_W       8
`define LC_CFG_DATA_W       32
`define LC_CFG_CABLE_ADDR   8'd18     // cable property word
`define LC_USB4_ID          8'h40     // cable id in bits 7:0
`define LC_CABLE_GEN4_BIT   21
`define LC_CABLE_GEN3_BIT   20

////////////////////////////////////////////////////////////////////////
// sideband transactions
////////////////////////////////////////////////////////////////////////

`define LC_PAYLOAD_W        24
`define LC_PEER_GEN4_BIT    18        // inside the AT response payload
`define LC_PEER_GEN3_BIT    13
`define LC_TSEL_W           3
`define LC_TSEL_IDLE        3'd0
`define LC_TSEL_AT_REQ      3'd2

// width of the sent ordered set counter
`define LC_CNT_W            6

`endif

// File: common/lane_ctrl_pkg.sv
package lane_ctrl_pkg;

  `include "lane_ctrl_macros.svh"

  typedef enum logic [3:0] {
    DISABLED              = 4'd0,
    CLD_CABLE_PROP        = 4'd1,
    CLD_DET_DEVICE        = 4'd2,
    CLD_PARAMETERS_1      = 4'd3,
    CLD_PARAMETERS_2      = 4'd4,
    CLD_CLK_SWITCH        = 4'd5,
    TRAINING_GEN4_TS1     = 4'd6,
    TRAINING_GEN4_TS2     = 4'd7,
    TRAINING_GEN4_TS3     = 4'd8,
    TRAINING_GEN4_TS4     = 4'd9,
    TRAINING_GEN2_3_SLOS1 = 4'd10,
    TRAINING_GEN2_3_SLOS2 = 4'd11,
    TRAINING_GEN2_3_TS1   = 4'd12,
    TRAINING_GEN2_3_TS2   = 4'd13,
    CL0                   = 4'd14
  } link_state_e;

  typedef enum logic [1:0] {GEN4 = 2'd0, GEN3 = 2'd1, GEN2 = 2'd2} gen_e;

  typedef enum logic [3:0] {
    SLOS1   = 4'd0,
    SLOS2   = 4'd1,
    G23_TS1 = 4'd2,
    G23_TS2 = 4'd3,
    G4_TS1  = 4'd4,
    G4_TS2  = 4'd5,
    G4_TS3  = 4'd6,
    G4_TS4  = 4'd7,
    DATA    = 4'd8,
    ZEROS   = 4'd9
  } os_code_e;

  typedef struct packed {
    os_code_e lane1;
    os_code_e lane0;
  } os_rx_t;

  typedef struct packed {
    logic [`LC_CFG_ADDR_W-1:0] addr;
    logic                      read;
  } cfg_req_t;

  typedef struct packed {
    os_code_e              os;          // sent and expected on both lanes
    logic [`LC_CNT_W-1:0]  sent_target;
    logic [1:0]            rx_target;   // per lane
    logic                  wait_sym;    // step also ends on a new symbol
  } train_step_t;

  // ordered set targets of every training step
  function automatic train_step_t train_step_of(link_state_e st, gen_e gen);
    train_step_t s;
    s = '{ZEROS, `LC_CNT_W'(0), 2'd0, 1'b0};
    case (st)
      TRAINING_GEN4_TS1:     s = '{G4_TS1, `LC_CNT_W'(16), 2'd1, 1'b0};
      TRAINING_GEN4_TS2:     s = '{G4_TS2, `LC_CNT_W'(16), 2'd1, 1'b0};
      TRAINING_GEN4_TS3:     s = '{G4_TS3, `LC_CNT_W'(16), 2'd1, 1'b0};
      TRAINING_GEN4_TS4:     s = '{G4_TS4, `LC_CNT_W'(16), 2'd1, 1'b1};
      TRAINING_GEN2_3_SLOS1: s = '{SLOS1, `LC_CNT_W'(2), 2'd2, 1'b0};
      TRAINING_GEN2_3_SLOS2: s = '{SLOS2, `LC_CNT_W'(2), 2'd2, 1'b0};
      TRAINING_GEN2_3_TS1:
        s = '{G23_TS1, (gen == GEN2) ? `LC_CNT_W'(32) : `LC_CNT_W'(16), 2'd2, 1'b0};
      TRAINING_GEN2_3_TS2:
        s = '{G23_TS2, (gen == GEN2) ? `LC_CNT_W'(16) : `LC_CNT_W'(8), 2'd2, 1'b1};
      default: ;
    endcase
    return s;
  endfunction

endpackage

// File: cld/cld_param_exchange.sv
`timescale 1ns/1ps

`include "lane_ctrl_macros.svh"

module cld_param_exchange
  import lane_ctrl_pkg::*;
(
  input  logic                      fsm_clk,
  input  logic                      reset_n,
  input  link_state_e               state_i,
  input  logic [`LC_CFG_DATA_W-1:0] cfg_data_i,
  input  logic                      t_valid_i,
  input  logic                      trans_error_i,
  input  logic [`LC_PAYLOAD_W-1:0]  payload_i,
  input  logic                      sync_busy_i,
  output cfg_req_t                  cfg_req_o,
  output logic [`LC_TSEL_W-1:0]     trans_sel_o,
  output logic                      disconnect_sbtx_o,
  output logic                      cable_ok_o,
  output gen_e                      gen_speed_o,
  output logic                      at_resp_ok_o
);

  gen_e cable_gen;
  gen_e peer_gen;
  logic req_pending;
  logic req_issue;

  // highest supported generation from two capability bits
  function automatic gen_e gen_from_caps(logic g4, logic g3);
    return g4 ? GEN4 : (g3 ? GEN3 : GEN2);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // cable properties
  //////////////////////////////////////////////////////////////////////

  assign cfg_req_o.addr = (state_i == CLD_CABLE_PROP) ? `LC_CFG_CABLE_ADDR : '0;
  assign cfg_req_o.read = (state_i == CLD_CABLE_PROP);

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cable_ok_o <= 1'b0;
      cable_gen  <= GEN4;
    end
    else if (state_i == DISABLED)
    begin
      cable_ok_o <= 1'b0;
      cable_gen  <= GEN4;
    end
    else if (state_i == CLD_CABLE_PROP)
    begin
      cable_ok_o <= (cfg_data_i[7:0] == `LC_USB4_ID);
      cable_gen  <= gen_from_caps(cfg_data_i[`LC_CABLE_GEN4_BIT], cfg_data_i[`LC_CABLE_GEN3_BIT]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AT parameter request and response
  //////////////////////////////////////////////////////////////////////

  assign at_resp_ok_o = t_valid_i && !trans_error_i;
  assign req_issue    = (state_i == CLD_PARAMETERS_1) && req_pending && !sync_busy_i;

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      req_pending <= 1'b1;
      trans_sel_o <= `LC_TSEL_IDLE;
      peer_gen    <= GEN4;
    end
    else
    begin
      if (state_i != CLD_PARAMETERS_1)
        req_pending <= 1'b1;                                   // armed for the next entry
      else if (req_issue)
        req_pending <= 1'b0;
      else if (trans_error_i)
        req_pending <= 1'b1;                                   // ask again
      trans_sel_o <= req_issue ? `LC_TSEL_AT_REQ : `LC_TSEL_IDLE;

      if (state_i == DISABLED)
        peer_gen <= GEN4;
      else if (state_i == CLD_PARAMETERS_1 && at_resp_ok_o)
        peer_gen <= gen_from_caps(payload_i[`LC_PEER_GEN4_BIT], payload_i[`LC_PEER_GEN3_BIT]);
    end
  end

  // slower generation has the larger code
  assign gen_speed_o       = (cable_gen > peer_gen) ? cable_gen : peer_gen;
  assign disconnect_sbtx_o = (state_i == DISABLED) || (state_i == CLD_CABLE_PROP);

  a_at_req_single: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    (trans_sel_o == `LC_TSEL_AT_REQ) |=> (trans_sel_o != `LC_TSEL_AT_REQ));

endmodule

// File: training/os_handshake_counter.sv
`timescale 1ns/1ps

`include "lane_ctrl_macros.svh"

module os_handshake_counter
  import lane_ctrl_pkg::*;
(
  input  logic        fsm_clk,
  input  logic        reset_n,
  input  link_state_e state_i,
  input  gen_e        gen_speed_i,
  input  logic        step_clr_i,
  input  logic        os_sent_i,
  input  os_rx_t      os_rx_i,
  output logic        step_done_o
);

  train_step_t          step;
  logic [`LC_CNT_W-1:0] sent_cnt;
  logic [1:0]           rx_cnt [2];
  os_code_e             lane_os [2];

  assign step       = train_step_of(state_i, gen_speed_i);
  assign lane_os[0] = os_rx_i.lane0;
  assign lane_os[1] = os_rx_i.lane1;

  //////////////////////////////////////////////////////////////////////
  // sent and received counts
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      sent_cnt <= '0;
    else if (step_clr_i)
      sent_cnt <= '0;                                          // new step starts from zero
    else if (os_sent_i && sent_cnt < step.sent_target)
      sent_cnt <= sent_cnt + 1'b1;
  end

  for (genvar i = 0; i < 2; i++)
  begin : g_lane
    always_ff @(posedge fsm_clk or negedge reset_n)
    begin
      if (!reset_n)
        rx_cnt[i] <= 2'd0;
      else if (step_clr_i)
        rx_cnt[i] <= 2'd0;
      else if (lane_os[i] == step.os && rx_cnt[i] < step.rx_target)
        rx_cnt[i] <= rx_cnt[i] + 2'd1;                         // only the step's own os counts
    end
  end

  assign step_done_o = (sent_cnt == step.sent_target)
                    && (rx_cnt[0] == step.rx_target)
                    && (rx_cnt[1] == step.rx_target);

  // holds only if the FSM clears on every step change
  a_cnt_bounded: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    (sent_cnt <= step.sent_target) && (rx_cnt[0] <= step.rx_target)
      && (rx_cnt[1] <= step.rx_target));

endmodule

// File: rtl/link_state_fsm.sv
`timescale 1ns/1ps

module link_state_fsm
  import lane_ctrl_pkg::*;
(
  input  logic        fsm_clk,
  input  logic        reset_n,
  input  logic        lane_disable_i,
  input  logic        disconnect_sbrx_i,
  input  logic        tdisabled_min_i,
  input  logic        ttraining_error_timeout_i,
  input  logic        host_i,
  input  logic        new_sym_i,
  input  logic        trans_sent_i,
  input  logic        cable_ok_i,
  input  logic        at_resp_ok_i,
  input  logic        step_done_i,
  input  gen_e        gen_speed_i,
  output link_state_e state_o,
  output logic        step_clr_o,
  output os_code_e    d_sel_o,
  output logic        fsm_disabled_o,
  output logic        fsm_training_o,
  output logic        ts1_gen4_o,
  output logic        ts2_gen4_o
);

  link_state_e state_q;
  link_state_e next_state;
  train_step_t cur_step;
  logic        step_end;
  logic        in_training;
  logic        past_det;

  assign cur_step    = train_step_of(state_q, gen_speed_i);
  assign step_end    = step_done_i && (!cur_step.wait_sym || new_sym_i);
  assign in_training = (state_q >= TRAINING_GEN4_TS1) && (state_q <= TRAINING_GEN2_3_TS2);
  assign past_det    = (state_q >= CLD_PARAMETERS_1) && (state_q <= CL0);

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      state_q <= DISABLED;
    else
      state_q <= next_state;
  end

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next_state = state_q;
    case (state_q)
      DISABLED:         if (tdisabled_min_i) next_state = CLD_CABLE_PROP;  // min time in DISABLED
      CLD_CABLE_PROP:   if (cable_ok_i) next_state = CLD_DET_DEVICE;
      CLD_DET_DEVICE:
        if (!disconnect_sbrx_i)
          next_state = host_i ? CLD_PARAMETERS_1 : CLD_PARAMETERS_2;
      CLD_PARAMETERS_1:                                         // AT response back
        if (at_resp_ok_i)
          next_state = host_i ? CLD_PARAMETERS_2 : CLD_CLK_SWITCH;
      CLD_PARAMETERS_2:                                         // our AT response out
        if (trans_sent_i)
          next_state = host_i ? CLD_CLK_SWITCH : CLD_PARAMETERS_1;
      CLD_CLK_SWITCH:
        if (new_sym_i)
          next_state = (gen_speed_i == GEN4) ? TRAINING_GEN4_TS1 : TRAINING_GEN2_3_SLOS1;
      TRAINING_GEN4_TS1, TRAINING_GEN4_TS2, TRAINING_GEN4_TS3,
      TRAINING_GEN2_3_SLOS1, TRAINING_GEN2_3_SLOS2, TRAINING_GEN2_3_TS1:
        if (step_end)
          next_state = link_state_e'(state_q + 4'd1);           // steps are numbered in order
      TRAINING_GEN4_TS4, TRAINING_GEN2_3_TS2:
        if (step_end)
          next_state = CL0;
      CL0:              next_state = CL0;
      default:          next_state = DISABLED;
    endcase

    // fallbacks, lowest priority first
    if (in_training && ttraining_error_timeout_i)
      next_state = CLD_PARAMETERS_1;
    if (past_det && disconnect_sbrx_i)
      next_state = CLD_DET_DEVICE;
    if (lane_disable_i)
      next_state = DISABLED;
  end

  assign step_clr_o = (next_state != state_q);
  assign state_o    = state_q;

  //////////////////////////////////////////////////////////////////////
  // lane select and status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      d_sel_o        <= ZEROS;
      fsm_disabled_o <= 1'b1;
      fsm_training_o <= 1'b0;
      ts1_gen4_o     <= 1'b0;
      ts2_gen4_o     <= 1'b0;
    end
    else
    begin
      // data goes out as soon as CL0 is decided
      d_sel_o        <= (state_q == CL0 || next_state == CL0) ? DATA : cur_step.os;
      fsm_disabled_o <= (state_q == DISABLED);
      fsm_training_o <= in_training;
      ts1_gen4_o     <= (state_q == TRAINING_GEN4_TS1);
      ts2_gen4_o     <= (state_q == TRAINING_GEN4_TS2);
    end
  end

  a_state_legal: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    state_q <= CL0);

  // a clear strobe is always followed by a new state
  a_clr_moves: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    step_clr_o |=> !$stable(state_q));

endmodule

// File: rtl/lane_ctrl_top.sv
`timescale 1ns/1ps

`include "lane_ctrl_macros.svh"

module lane_ctrl_top
  import lane_ctrl_pkg::*;
(
  input  logic                      fsm_clk,
  input  logic                      reset_n,
  input  os_rx_t                    os_rx_i,
  input  logic                      os_sent_i,
  input  logic                      new_sym_i,
  input  logic                      host_i,
  input  logic                      lane_disable_i,
  input  logic                      disconnect_sbrx_i,
  input  logic                      tdisabled_min_i,
  input  logic                      ttraining_error_timeout_i,
  input  logic                      t_valid_i,
  input  logic                      trans_error_i,
  input  logic                      trans_sent_i,
  input  logic [`LC_PAYLOAD_W-1:0]  payload_i,
  input  logic                      sync_busy_i,
  input  logic [`LC_CFG_DATA_W-1:0] cfg_data_i,
  output cfg_req_t                  cfg_req_o,
  output logic [`LC_TSEL_W-1:0]     trans_sel_o,
  output logic                      disconnect_sbtx_o,
  output os_code_e                  d_sel_o,
  output gen_e                      gen_speed_o,
  output link_state_e               fsm_state_o,
  output logic                      fsm_disabled_o,
  output logic                      fsm_training_o,
  output logic                      ts1_gen4_o,
  output logic                      ts2_gen4_o
);

  link_state_e state;
  logic        step_clr;
  logic        cable_ok;
  logic        at_resp_ok;
  logic        step_done;

  link_state_fsm u_fsm (
    .fsm_clk, .reset_n, .lane_disable_i, .disconnect_sbrx_i, .tdisabled_min_i,
    .ttraining_error_timeout_i, .host_i, .new_sym_i, .trans_sent_i,
    .cable_ok_i(cable_ok), .at_resp_ok_i(at_resp_ok), .step_done_i(step_done),
    .gen_speed_i(gen_speed_o), .state_o(state), .step_clr_o(step_clr), .d_sel_o,
    .fsm_disabled_o, .fsm_training_o, .ts1_gen4_o, .ts2_gen4_o
  );

  cld_param_exchange u_cld (
    .fsm_clk, .reset_n, .state_i(state), .cfg_data_i, .t_valid_i, .trans_error_i,
    .payload_i, .sync_busy_i, .cfg_req_o, .trans_sel_o, .disconnect_sbtx_o,
    .cable_ok_o(cable_ok), .gen_speed_o, .at_resp_ok_o(at_resp_ok)
  );

  os_handshake_counter u_cnt (
    .fsm_clk, .reset_n, .state_i(state), .gen_speed_i(gen_speed_o),
    .step_clr_i(step_clr), .os_sent_i, .os_rx_i, .step_done_o(step_done)
  );

  assign fsm_state_o = state;

endmodule

// File: testbench/lane_ctrl_tb.sv
`timescale 1ns/1ps

`include "lane_ctrl_macros.svh"

module lane_ctrl_tb
  import lane_ctrl_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int POLL_SHORT   = 40;
  localparam int POLL_LINK    = 500;
  // 7 resets, 8 short polls, 7 link polls and the fixed waits
  localparam int WATCHDOG_CYCLES = 7 * (RESET_CYCLES + 2) + 8 * POLL_SHORT
                                 + 7 * POLL_LINK + 64;

  localparam logic [31:0] CABLE_GEN4  = 32'h0030_0040;  // id 0x40, bits 21 and 20
  localparam logic [31:0] CABLE_GEN3  = 32'h0010_0040;  // id 0x40, bit 20 only
  localparam logic [31:0] CABLE_NO_ID = 32'h0030_0000;
  localparam logic [23:0] PEER_GEN4   = 24'h04_2000;    // bits 18 and 13
  localparam logic [23:0] PEER_GEN2   = 24'h00_0000;

  logic                      fsm_clk = 1'b0;
  logic                      reset_n = 1'b0;
  os_rx_t                    os_rx_i = '{ZEROS, ZEROS};
  logic                      os_sent_i = 1'b0;
  logic                      new_sym_i = 1'b0;
  logic                      host_i = 1'b1;
  logic                      lane_disable_i = 1'b0;
  logic                      disconnect_sbrx_i = 1'b0;
  logic                      tdisabled_min_i = 1'b0;
  logic                      ttraining_error_timeout_i = 1'b0;
  logic                      t_valid_i = 1'b0;
  logic                      trans_error_i = 1'b0;
  logic                      trans_sent_i = 1'b0;
  logic [`LC_PAYLOAD_W-1:0]  payload_i = '0;
  logic                      sync_busy_i = 1'b0;
  logic [`LC_CFG_DATA_W-1:0] cfg_data_i = '0;
  cfg_req_t                  cfg_req_o;
  logic [`LC_TSEL_W-1:0]     trans_sel_o;
  logic                      disconnect_sbtx_o;
  os_code_e                  d_sel_o;
  gen_e                      gen_speed_o;
  link_state_e               fsm_state_o;
  logic                      fsm_disabled_o;
  logic                      fsm_training_o;
  logic                      ts1_gen4_o;
  logic                      ts2_gen4_o;

  // model controls, changed only at the falling edge
  logic [31:0] cable_word = '0;
  logic [23:0] peer_payload = '0;
  int          errors_wanted = 0;
  bit          traffic_en = 1'b0;

  int          errors_sent;
  int          resp_timer;
  int          at_req_cnt;
  logic [1:0]  sym_div;
  link_state_e prev_state;
  os_code_e    dsel_log [$];
  int          ts1_hits;
  int          ts2_hits;
  int          flag_mismatch;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          mark;

  lane_ctrl_top DUT (.*);

  always #(CLK_PERIOD / 2) fsm_clk = ~fsm_clk;

  ////////////////////////////////////////////////////////////////////
  // configuration space and peer models
  ////////////////////////////////////////////////////////////////////

  always @(posedge fsm_clk)
  begin
    cfg_data_i <= (cfg_req_o.read && cfg_req_o.addr == `LC_CFG_CABLE_ADDR) ? cable_word : '0;
  end

  always @(posedge fsm_clk)
  begin
    if (!reset_n)
    begin
      os_sent_i <= 1'b0;
      new_sym_i <= 1'b0;
      sym_div   <= 2'd0;
    end
    else
    begin
      sym_div   <= sym_div + 2'd1;
      new_sym_i <= traffic_en && (sym_div == 2'd3);           // new symbol every 4th cycle
      os_sent_i <= traffic_en && !os_sent_i;
    end
    os_rx_i <= '{d_sel_o, d_sel_o};                             // far end echoes our lanes
  end

  always @(posedge fsm_clk)
  begin
    if (!reset_n)
    begin
      at_req_cnt    <= 0;
      resp_timer    <= 0;
      errors_sent   <= 0;
      t_valid_i     <= 1'b0;
      trans_error_i <= 1'b0;
      trans_sent_i  <= 1'b0;
    end
    else
    begin
      if (trans_sel_o == `LC_TSEL_AT_REQ)
      begin
        at_req_cnt <= at_req_cnt + 1;
        resp_timer <= 3;                                        // answer a few cycles later
      end
      else if (resp_timer != 0)
        resp_timer <= resp_timer - 1;
      t_valid_i     <= (resp_timer == 1);
      trans_error_i <= (resp_timer == 1) && (errors_sent < errors_wanted);
      if (resp_timer == 1 && errors_sent < errors_wanted)
        errors_sent <= errors_sent + 1;
      payload_i    <= peer_payload;
      trans_sent_i <= (fsm_state_o == CLD_PARAMETERS_2) && !trans_sent_i;
    end
  end

  // lane OS order and status flags, which follow the state by one cycle
  always @(posedge fsm_clk)
  begin
    if (!reset_n)
    begin
      dsel_log.delete();
      prev_state    <= DISABLED;
      ts1_hits      <= 0;
      ts2_hits      <= 0;
      flag_mismatch <= 0;
    end
    else
    begin
      prev_state <= fsm_state_o;
      if (d_sel_o != ZEROS && d_sel_o != DATA
          && (dsel_log.size() == 0 || dsel_log[$] != d_sel_o))
        dsel_log.push_back(d_sel_o);
      if (ts1_gen4_o && prev_state == TRAINING_GEN4_TS1)
        ts1_hits <= ts1_hits + 1;
      if (ts2_gen4_o && prev_state == TRAINING_GEN4_TS2)
        ts2_hits <= ts2_hits + 1;
      if (ts1_gen4_o != (prev_state == TRAINING_GEN4_TS1)
          || ts2_gen4_o != (prev_state == TRAINING_GEN4_TS2)
          || fsm_disabled_o != (prev_state == DISABLED)
          || fsm_training_o != is_training_state(prev_state))
        flag_mismatch <= flag_mismatch + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  // every OS training step of both paths
  function automatic bit is_training_state(input link_state_e st);
    return st inside {TRAINING_GEN4_TS1, TRAINING_GEN4_TS2, TRAINING_GEN4_TS3,
                      TRAINING_GEN4_TS4, TRAINING_GEN2_3_SLOS1, TRAINING_GEN2_3_SLOS2,
                      TRAINING_GEN2_3_TS1, TRAINING_GEN2_3_TS2};
  endfunction

  task automatic check(input bit ok, input string msg);
    assert (ok) pass_cnt++;
    else
    begin
      $display("ERR %0t: %s", $time, msg);
      fail_cnt++;
    end
  endtask

  task automatic wait_for_state(input link_state_e target, input int limit);
    int n;
    n = 0;
    @(negedge fsm_clk);
    while (fsm_state_o != target && n < limit)
    begin
      @(negedge fsm_clk);
      n++;
    end
    assert (fsm_state_o == target) pass_cnt++;
    else
    begin
      $display("state %s was not reached within %0d cycles", target.name(), limit);
      fail_cnt++;
    end
  endtask

  task automatic apply_reset();
    @(posedge fsm_clk);
    reset_n                   <= 1'b0;
    host_i                    <= 1'b1;
    tdisabled_min_i           <= 1'b0;
    lane_disable_i            <= 1'b0;
    disconnect_sbrx_i         <= 1'b0;
    ttraining_error_timeout_i <= 1'b0;
    sync_busy_i               <= 1'b0;
    @(negedge fsm_clk);
    traffic_en    = 1'b0;
    cable_word    = '0;
    peer_payload  = '0;
    errors_wanted = 0;
    repeat (RESET_CYCLES) @(posedge fsm_clk);
    reset_n <= 1'b1;
    @(negedge fsm_clk);
  endtask

  task automatic link_up(input bit host, input logic [31:0] cable, input logic [23:0] peer,
                         input int errors);
    apply_reset();
    cable_word    = cable;
    peer_payload  = peer;
    errors_wanted = errors;
    traffic_en    = 1'b1;
    @(posedge fsm_clk);
    host_i          <= host;
    tdisabled_min_i <= 1'b1;
  endtask

  task automatic check_os_order(input os_code_e exp [4]);
    bit same;
    int i;
    same = (dsel_log.size() == 4);
    for (i = 0; i < 4 && same; i++)
      same = (dsel_log[i] == exp[i]);
    check(same, $sformatf("lane OS order wrong, %0d steps logged", dsel_log.size()));
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("%-16s done, %0d failed checks", name, fail_cnt - fails_before);
  endtask

  ////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    apply_reset();
    check(fsm_state_o == DISABLED && fsm_disabled_o && d_sel_o == ZEROS,
          $sformatf("after reset state %s d_sel %s", fsm_state_o.name(), d_sel_o.name()));
    check(disconnect_sbtx_o && trans_sel_o == `LC_TSEL_IDLE && !cfg_req_o.read,
          "sideband outputs not idle after reset");
    check(!fsm_training_o && !ts1_gen4_o && !ts2_gen4_o && gen_speed_o == GEN4,
          "status outputs not cleared after reset");
    repeat (8) @(negedge fsm_clk);
    check(fsm_state_o == DISABLED, "left DISABLED without tdisabled_min_i");
    @(posedge fsm_clk);
    tdisabled_min_i <= 1'b1;
    wait_for_state(CLD_CABLE_PROP, POLL_SHORT);
  endtask

  task automatic cable_detect();
    apply_reset();
    cable_word = CABLE_NO_ID;
    traffic_en = 1'b1;
    @(posedge fsm_clk);
    tdisabled_min_i   <= 1'b1;
    disconnect_sbrx_i <= 1'b1;                                  // parks the FSM in device detect
    wait_for_state(CLD_CABLE_PROP, POLL_SHORT);
    repeat (10) @(negedge fsm_clk);
    check(fsm_state_o == CLD_CABLE_PROP, "left cable detect with a bad cable id");
    check(cfg_req_o.addr == `LC_CFG_CABLE_ADDR && cfg_req_o.read,
          $sformatf("cfg_req addr %0d read %0b", cfg_req_o.addr, cfg_req_o.read));
    check(disconnect_sbtx_o, "sideband tx not disconnected in cable detect");
    cable_word = CABLE_GEN4;
    wait_for_state(CLD_DET_DEVICE, POLL_SHORT);
  endtask

  task automatic host_gen4_link();
    link_up(1'b1, CABLE_GEN4, PEER_GEN4, 0);
    wait_for_state(CL0, POLL_LINK);
    check(at_req_cnt == 1, $sformatf("%0d AT requests, expected 1", at_req_cnt));
    check_os_order('{G4_TS1, G4_TS2, G4_TS3, G4_TS4});
    check(ts1_hits > 0 && ts2_hits > 0 && flag_mismatch == 0,
          $sformatf("ts flags hit %0d/%0d, %0d flag mismatches", ts1_hits, ts2_hits,
                    flag_mismatch));
    check(d_sel_o == DATA, $sformatf("d_sel %s in CL0", d_sel_o.name()));
    check(gen_speed_o == GEN4, $sformatf("gen_speed %s", gen_speed_o.name()));
    check(!disconnect_sbtx_o, "sideband tx still disconnected in CL0");
  endtask

  task automatic gen23_link(input logic [31:0] cable, input logic [23:0] peer, input gen_e exp);
    link_up(1'b1, cable, peer, 1);                              // first response has an error
    wait_for_state(CL0, POLL_LINK);
    check(gen_speed_o == exp,
          $sformatf("gen_speed %s, expected %s", gen_speed_o.name(), exp.name()));
    check_os_order('{SLOS1, SLOS2, G23_TS1, G23_TS2});
    check(at_req_cnt == 2, $sformatf("%0d AT requests, expected 2", at_req_cnt));
    check(d_sel_o == DATA, $sformatf("d_sel %s in CL0", d_sel_o.name()));
    check(flag_mismatch == 0, $sformatf("%0d status flag mismatches", flag_mismatch));
  endtask

  task automatic device_role();
    link_up(1'b0, CABLE_GEN4, PEER_GEN4, 0);
    wait_for_state(CLD_PARAMETERS_2, POLL_SHORT);
    check(prev_state == CLD_DET_DEVICE, $sformatf("PARAMETERS_2 entered from %s",
          prev_state.name()));
    wait_for_state(CLD_PARAMETERS_1, POLL_SHORT);
    check(prev_state == CLD_PARAMETERS_2, $sformatf("PARAMETERS_1 entered from %s",
          prev_state.name()));
    wait_for_state(CL0, POLL_LINK);
  endtask

  task automatic fallbacks();
    link_up(1'b1, CABLE_GEN4, PEER_GEN4, 0);
    wait_for_state(TRAINING_GEN4_TS2, POLL_LINK);
    @(posedge fsm_clk);
    disconnect_sbrx_i <= 1'b1;
    wait_for_state(CLD_DET_DEVICE, POLL_SHORT);
    @(posedge fsm_clk);
    disconnect_sbrx_i <= 1'b0;
    wait_for_state(TRAINING_GEN4_TS1, POLL_LINK);
    @(posedge fsm_clk);
    ttraining_error_timeout_i <= 1'b1;
    @(posedge fsm_clk);
    ttraining_error_timeout_i <= 1'b0;
    wait_for_state(CLD_PARAMETERS_1, POLL_SHORT);
    wait_for_state(CL0, POLL_LINK);
    @(posedge fsm_clk);
    lane_disable_i <= 1'b1;
    wait_for_state(DISABLED, POLL_SHORT);
    check(disconnect_sbtx_o, "sideband tx not disconnected after lane disable");
    check(flag_mismatch == 0, $sformatf("%0d status flag mismatches", flag_mismatch));
    @(posedge fsm_clk);
    lane_disable_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // sequence, watchdog and summary
  ////////////////////////////////////////////////////////////////////

  initial
  begin
    mark = fail_cnt;
    reset_values();
    report_test("reset", mark);
    mark = fail_cnt;
    cable_detect();
    report_test("cable detect", mark);
    mark = fail_cnt;
    host_gen4_link();
    report_test("host gen4", mark);
    mark = fail_cnt;
    gen23_link(CABLE_GEN3, PEER_GEN4, GEN3);
    report_test("gen3 cable", mark);
    mark = fail_cnt;
    gen23_link(CABLE_GEN4, PEER_GEN2, GEN2);
    report_test("gen2 peer", mark);
    mark = fail_cnt;
    device_role();
    report_test("device role", mark);
    mark = fail_cnt;
    fallbacks();
    report_test("fallbacks", mark);
    $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+common
common/lane_ctrl_pkg.sv
cld/cld_param_exchange.sv
training/os_handshake_counter.sv
rtl/link_state_fsm.sv
rtl/lane_ctrl_top.sv
testbench/lane_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the lane controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module lane_ctrl_tb; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vlane_ctrl_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
